/* verilog/freq_pkg.sv */
/*
 frequency counter shared definitions
 gate timing, digit count, scan rate and the words passed between blocks
*/

package freq_pkg;

	// gate window in system clocks
	localparam logic [12:0] gate_cycles = 13'd4096;

	// edge count width, wide enough for any window
	localparam int count_width = 24;

	// display geometry and scan rate
	localparam int bcd_digits = 8;
	localparam int digit_cycles = 16;

	// position of the lit decimal point
	localparam int dp_digit = 2;

	// one window's edge count with its strobe
	typedef struct packed {
		logic [count_width-1:0] value;
		logic valid;
	} count_t;

	// packed bcd, digit 0 in the low nibble
	typedef logic [bcd_digits-1:0][3:0] bcd_t;

	// segments g,f,e,d,c,b,a,dp and one-hot anodes, both active high
	typedef struct packed {
		logic [7:0] cathode;
		logic [7:0] anode;
	} display_t;

endpackage

/* verilog/edge_gate_counter.sv */
/*
 gated edge counter
 synchronizes the unknown signal, counts its rising edges over each
 gate window and publishes the total on the last cycle of the window
*/

`timescale 1ns/1ps

module edge_gate_counter (
	input logic clock,
	input logic reset,
	input logic unknown,
	output freq_pkg::count_t count
);

	// two flop synchronizer then the edge detect flop
	logic sync_1;
	logic sync_2;
	logic detect;
	logic rising;

	// position inside the current window
	logic [12:0] gate_count;
	logic last_cycle;

	// edges seen so far this window
	logic [freq_pkg::count_width-1:0] edges;

	always_ff @(posedge clock) begin
		if (reset) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
			detect <= 1'b0;
		end else begin
			sync_1 <= unknown;
			sync_2 <= sync_1;
			detect <= sync_2;
		end
	end

	// new high level that the detect flop has not yet seen
	assign rising = sync_2 & ~detect;

	assign last_cycle = (gate_count == freq_pkg::gate_cycles - 13'd1);

	always_ff @(posedge clock) begin
		if (reset) begin
			gate_count <= '0;
		end else if (last_cycle) begin
			gate_count <= '0;
		end else begin
			gate_count <= gate_count + 13'd1;
		end
	end

	// on the last cycle publish the total, restart with this cycle's edge
	always_ff @(posedge clock) begin
		if (reset) begin
			edges <= '0;
			count.valid <= 1'b0;
			count.value <= '0;
		end else begin
			count.valid <= last_cycle;
			if (last_cycle) begin
				count.value <= edges;
				edges <= rising ? freq_pkg::count_width'(1) : '0;
			end else if (rising) begin
				edges <= edges + 1'b1;
			end
		end
	end

endmodule

/* verilog/hex2bcd.sv */
/*
 binary to bcd converter
 sequential double dabble, one input bit per clock,
 done pulses 25 clocks after start
*/

`timescale 1ns/1ps

module hex2bcd (
	input logic clock,
	input logic reset,
	input logic start,
	input logic [freq_pkg::count_width-1:0] binary,
	output freq_pkg::bcd_t bcd,
	output logic done
);

	localparam int step_width = $clog2(freq_pkg::count_width + 1);

	logic busy;
	logic [step_width-1:0] step;

	// working registers, binary bits leave from the top
	logic [freq_pkg::count_width-1:0] shifter;
	freq_pkg::bcd_t work;

	// any digit of five or more gets three added before the shift
	function automatic freq_pkg::bcd_t add_three(input freq_pkg::bcd_t value);
		freq_pkg::bcd_t result;
		result = value;
		for (int i = 0; i < freq_pkg::bcd_digits; i++) begin
			if (value[i] >= 4'd5) begin
				result[i] = value[i] + 4'd3;
			end
		end
		return result;
	endfunction

	// control
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			step <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				// start while busy is simply not looked at
				if (start) begin
					busy <= 1'b1;
					step <= '0;
				end
			end else if (step == step_width'(freq_pkg::count_width)) begin
				// finish cycle
				busy <= 1'b0;
				done <= 1'b1;
			end else begin
				step <= step + 1'b1;
			end
		end
	end

	// datapath
	always_ff @(posedge clock) begin
		if (!busy && start) begin
			shifter <= binary;
			work <= '0;
		end else if (busy && step != step_width'(freq_pkg::count_width)) begin
			{work, shifter} <= {add_three(work), shifter} << 1;
		end
	end

	// result held until the next finish
	always_ff @(posedge clock) begin
		if (busy && step == step_width'(freq_pkg::count_width)) begin
			bcd <= work;
		end
	end

endmodule

/* verilog/segment_scanner.sv */
/*
 seven segment scanner
 steps through the eight bcd digits, drives one anode at a time
 and decodes the selected digit onto the shared segment lines
*/

`timescale 1ns/1ps

module segment_scanner (
	input logic clock,
	input logic reset,
	input freq_pkg::bcd_t digits,
	output freq_pkg::display_t display
);

	localparam int dwell_width = $clog2(freq_pkg::digit_cycles);
	localparam int index_width = $clog2(freq_pkg::bcd_digits);

	// clocks spent on the current digit
	logic [dwell_width-1:0] dwell;

	// digit now lit
	logic [index_width-1:0] index;

	logic [3:0] nibble;

	// segments g,f,e,d,c,b,a
	logic [6:0] segments;

	logic point;

	always_ff @(posedge clock) begin
		if (reset) begin
			dwell <= '0;
			index <= '0;
		end else if (dwell == dwell_width'(freq_pkg::digit_cycles - 1)) begin
			dwell <= '0;
			// wraps from digit 7 back to digit 0
			index <= index + 1'b1;
		end else begin
			dwell <= dwell + 1'b1;
		end
	end

	assign nibble = digits[index];

	// segment table, a is the low bit
	always_comb begin
		case (nibble)
			4'd0: segments = 7'b0111111;
			4'd1: segments = 7'b0000110;
			4'd2: segments = 7'b1011011;
			4'd3: segments = 7'b1001111;
			4'd4: segments = 7'b1100110;
			4'd5: segments = 7'b1101101;
			4'd6: segments = 7'b1111101;
			4'd7: segments = 7'b0000111;
			4'd8: segments = 7'b1111111;
			4'd9: segments = 7'b1101111;
			// non decimal codes stay dark
			default: segments = 7'b0000000;
		endcase
	end

	// fixed decimal point position
	assign point = (index == index_width'(freq_pkg::dp_digit));

	// same cycle as the anode, so cathode and anode always agree
	assign display.cathode = {segments, point};
	assign display.anode = 8'b1 << index;

endmodule

/* verilog/freq_display_top.sv */
/*
 frequency counter with seven segment readout
 counts edges per gate window, converts each count to bcd,
 buffers the reading and scans it onto the display
*/

`timescale 1ns/1ps

module freq_display_top (
	input logic clock,
	input logic reset,
	input logic unknown,
	output freq_pkg::bcd_t reading,
	output logic reading_valid,
	output freq_pkg::display_t display
);

	// counter result, strobed once per window
	freq_pkg::count_t count;

	// count held for the converter
	logic [freq_pkg::count_width-1:0] held_value;
	logic start;

	// converter result
	freq_pkg::bcd_t converted;
	logic done;

	edge_gate_counter edge_gate_counter_inst (
		.clock(clock),
		.reset(reset),
		.unknown(unknown),
		.count(count)
	);

	// capture the count, kick the converter one clock later
	always_ff @(posedge clock) begin
		if (count.valid) begin
			held_value <= count.value;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			start <= 1'b0;
		end else begin
			start <= count.valid;
		end
	end

	hex2bcd hex2bcd_inst (
		.clock(clock),
		.reset(reset),
		.start(start),
		.binary(held_value),
		.bcd(converted),
		.done(done)
	);

	// display buffer, also the reading port
	always_ff @(posedge clock) begin
		if (reset) begin
			reading <= '0;
			reading_valid <= 1'b0;
		end else begin
			reading_valid <= done;
			if (done) begin
				reading <= converted;
			end
		end
	end

	// scanner shows the buffer, not the converter's working value
	segment_scanner segment_scanner_inst (
		.clock(clock),
		.reset(reset),
		.digits(reading),
		.display(display)
	);

endmodule

/* bench/tb_freq_display.sv */
/*
 frequency counter testbench
 reads test lines from the stimulus file, drives a square wave
 on unknown and checks the bcd reading and the scanned display
*/

`timescale 1ns/1ps

module tb_freq_display;

	localparam int timeout_cycles = 3 * int'(freq_pkg::gate_cycles);

	logic clock;
	logic reset;
	logic unknown;
	freq_pkg::bcd_t reading;
	logic reading_valid;
	freq_pkg::display_t display;

	int errors;
	int tests;
	integer seed;

	// square wave generator state, half period in clocks
	int half_period;
	int phase_count;

	freq_display_top freq_display_top_inst (
		.clock(clock),
		.reset(reset),
		.unknown(unknown),
		.reading(reading),
		.reading_valid(reading_valid),
		.display(display)
	);

	// 8 ns period
	always #4 clock = ~clock;

	// unknown toggles every half_period clocks, held low when zero
	always @(posedge clock) begin
		#1;
		if (half_period == 0) begin
			unknown = 1'b0;
			phase_count = 0;
		end else if (phase_count >= half_period - 1) begin
			unknown = ~unknown;
			phase_count = 0;
		end else begin
			phase_count = phase_count + 1;
		end
	end

	// segments g..a for one decimal digit, blank otherwise
	function automatic logic [6:0] seven_segment(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'b0111111;
			4'd1: return 7'b0000110;
			4'd2: return 7'b1011011;
			4'd3: return 7'b1001111;
			4'd4: return 7'b1100110;
			4'd5: return 7'b1101101;
			4'd6: return 7'b1111101;
			4'd7: return 7'b0000111;
			4'd8: return 7'b1111111;
			4'd9: return 7'b1101111;
			default: return 7'b0000000;
		endcase
	endfunction

	// decimal digits of a count, digit 0 lowest
	function automatic freq_pkg::bcd_t decimal_digits(input int number);
		freq_pkg::bcd_t result;
		int rest;
		int i;
		rest = number;
		for (i = 0; i < freq_pkg::bcd_digits; i++) begin
			result[i] = 4'(rest % 10);
			rest = rest / 10;
		end
		return result;
	endfunction

	task automatic report_mismatch(input string label, input int expected, input int actual);
		$display("** Error %0s: expected %0d, actual %0d", label, expected, actual);
		errors++;
	endtask

	// outputs sampled mid cycle
	task automatic check_reset();
		if (reading_valid !== 1'b0) report_mismatch("reset_state reading_valid", 0, reading_valid);
		if (reading !== '0) report_mismatch("reset_state reading", 0, reading);
		if (display.anode !== 8'b1) report_mismatch("reset_state anode", 1, display.anode);
		if (display.cathode[7:1] !== seven_segment(4'd0)) begin
			report_mismatch("reset_state cathode", seven_segment(4'd0), display.cathode[7:1]);
		end
	endtask

	// one reading_valid pulse or a timeout
	task automatic wait_reading(input string test, output bit ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < timeout_cycles) begin
			@(negedge clock);
			if (reading_valid === 1'b1) ok = 1'b1;
			cycles++;
		end
		if (!ok) begin
			$display("timeout in test %0s: reading_valid never pulsed", test);
			errors++;
		end
	endtask

	// bcd form, then the whole word against counts near the nominal value
	task automatic check_reading(input string test, input int expected, input bit exact);
		int value;
		int lowest;
		int highest;
		int candidate;
		int i;
		bit matched;
		value = 0;
		for (i = freq_pkg::bcd_digits - 1; i >= 0; i--) begin
			if (reading[i] > 4'd9) report_mismatch({test, " digit range"}, 9, reading[i]);
			value = value * 10 + reading[i];
		end
		// a window never holds more than four decimal digits
		for (i = 4; i < freq_pkg::bcd_digits; i++) begin
			if (reading[i] !== 4'd0) report_mismatch({test, " upper digit"}, 0, reading[i]);
		end
		// phase of the signal against the gate moves the count by one
		lowest = exact ? expected : expected - 1;
		highest = exact ? expected : expected + 1;
		matched = 1'b0;
		for (candidate = lowest; candidate <= highest; candidate++) begin
			if (candidate >= 0 && reading === decimal_digits(candidate)) matched = 1'b1;
		end
		if (!matched) report_mismatch({test, " count"}, expected, value);
	endtask

	// one full scan of all eight positions
	task automatic check_scan(input string test);
		logic [7:0] seen;
		int pos;
		int c;
		int i;
		seen = '0;
		for (c = 0; c < 8 * freq_pkg::digit_cycles; c++) begin
			@(negedge clock);
			if (!$onehot(display.anode)) begin
				$display("test %0s: anode %b is not one-hot", test, display.anode);
				errors++;
			end else begin
				pos = 0;
				for (i = 0; i < 8; i++) begin
					if (display.anode[i]) pos = i;
				end
				seen[pos] = 1'b1;
				if (display.cathode[7:1] !== seven_segment(reading[pos])) begin
					report_mismatch({test, " segments"}, seven_segment(reading[pos]),
						display.cathode[7:1]);
				end
				if (display.cathode[0] !== display.anode[freq_pkg::dp_digit]) begin
					report_mismatch({test, " decimal point"}, display.anode[freq_pkg::dp_digit],
						display.cathode[0]);
				end
			end
		end
		if (seen !== 8'hff) begin
			$display("test %0s: not every digit position was lit, seen %b", test, seen);
			errors++;
		end
	endtask

	task automatic run_test(input string test, input int period, input int expected);
		bit ok;
		// period 1 stands for a random even period from 2 to 4096
		if (period == 1) begin
			period = 2 * (($random(seed) & 32'h7ff) + 1);
			expected = int'(freq_pkg::gate_cycles) / period;
		end
		$display("test %0s: period %0d, nominal count %0d", test, period, expected);
		@(posedge clock);
		half_period = period / 2;
		// first window mixes old and new signal
		wait_reading(test, ok);
		if (ok) wait_reading(test, ok);
		if (ok) begin
			check_reading(test, expected, period == 0);
			check_scan(test);
		end
		tests++;
	endtask

	initial begin
		int fd;
		int status;
		int fields;
		int period;
		int expected;
		string line;
		string name;
		clock = 1'b0;
		reset = 1'b1;
		unknown = 1'b0;
		half_period = 0;
		phase_count = 0;
		errors = 0;
		tests = 0;
		seed = 32'h37166edd;

		// reset held over four rising edges
		repeat (3) begin
			@(posedge clock);
			@(negedge clock);
			check_reset();
		end
		@(posedge clock);
		#1;
		reset = 1'b0;
		@(negedge clock);
		check_reset();
		@(negedge clock);
		check_reset();

		fd = $fopen("bench/freq_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open stimulus file bench/freq_input.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				status = $fgets(line, fd);
				// skip comments and blank lines
				if (status > 0 && line.len() > 0 && line.getc(0) != 8'h23) begin
					fields = $sscanf(line, "%s %d %d", name, period, expected);
					if (fields == 3) run_test(name, period, expected);
				end
			end
			$fclose(fd);
		end

		$display("tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* tb.f */
verilog/freq_pkg.sv
verilog/edge_gate_counter.sv
verilog/hex2bcd.sv
verilog/segment_scanner.sv
verilog/freq_display_top.sv
bench/tb_freq_display.sv

/* bench/freq_input.txt */
# columns: test name, unknown period in clocks, nominal count gate_cycles/period
# period 0 holds unknown low, period 1 asks for a random even period
max_frequency 2 2048
period_4 4 1024
period_6 6 682
period_8 8 512
period_10 10 409
period_14 14 292
period_32 32 128
period_50 50 81
period_64 64 64
period_100 100 40
period_250 250 16
period_512 512 8
period_1000 1000 4
slow_signal 2048 2
slowest 4096 1
zero_input 0 0
random_period 1 0
